// File: include/resize_consts.svh
`ifndef RESIZE_CONSTS_SVH
`define RESIZE_CONSTS_SVH

// line and source image geometry
`define LINE_W      64
`define SRC_W       32
`define SRC_H       32
`define FRAC_W      5
`define COL_W       10
`define ROW_W       10
`define PIX_W       24

// buffering and fixed latencies
`define FIFO_DEPTH  16
`define LERP_LAT    6
`define MEM_LAT     1

// apb register map
`define REG_RATE    4'h0
`define REG_ROI_BW  4'h4
`define REG_ROI_EW  4'h8
`define REG_STATUS  4'hC

`endif

// File: rtl/resize_pkg.sv
`include "resize_consts.svh"

package resize_pkg;

    // rate and roi bounds, 11 bits each
    typedef struct packed {
        logic [`COL_W:0]    rate;
        logic [`COL_W:0]    roi_bw;
        logic [`COL_W:0]    roi_ew;
    } resize_cfg_t;

    // vertical coordinate, 10.5 fixed point
    typedef struct packed {
        logic [`ROW_W-1:0]  h_int;
        logic [`FRAC_W-1:0] h_frac;
    } line_req_t;

    typedef struct packed {
        logic               re;
        logic [`ROW_W-1:0]  row_up;
        logic [`ROW_W-1:0]  row_dn;
        logic [`COL_W-1:0]  col;
    } mem_req_t;

    typedef struct packed {
        logic [`PIX_W-1:0]  up;
        logic [`PIX_W-1:0]  dn;
    } mem_rsp_t;

    // one token per memory read, or one per blank pixel
    typedef struct packed {
        logic               valid;
        logic               blank;
        logic [`FRAC_W-1:0] frac_w;
    } tap_tok_t;

    typedef struct packed {
        logic               valid;
        logic               blank;
        logic [`FRAC_W-1:0] frac_w;
        logic [`PIX_W-1:0]  up0;
        logic [`PIX_W-1:0]  up1;
        logic [`PIX_W-1:0]  dn0;
        logic [`PIX_W-1:0]  dn1;
    } taps_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } line_state_e;

endpackage

// File: rtl/resize_apb_regs.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module resize_apb_regs (
    input  logic                    clk,
    input  logic                    frst,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [3:0]              i_paddr,
    input  logic [31:0]             i_pwdata,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    input  logic                    i_busy,
    output resize_pkg::resize_cfg_t o_cfg
);

    localparam logic [`COL_W:0] RATE_ONE = 1 << `FRAC_W;
    localparam logic [`COL_W:0] LAST_X   = `LINE_W - 1;

    logic access;
    logic addr_ok;

    // zero wait states
    assign access    = i_psel & i_penable;
    assign o_pready  = access;
    assign o_pslverr = access & ~addr_ok;

    always_comb begin
        addr_ok  = 1'b1;
        o_prdata = '0;
        case (i_paddr)
            `REG_RATE:   o_prdata = {21'd0, o_cfg.rate};
            `REG_ROI_BW: o_prdata = {21'd0, o_cfg.roi_bw};
            `REG_ROI_EW: o_prdata = {21'd0, o_cfg.roi_ew};
            `REG_STATUS: o_prdata = {31'd0, i_busy};
            default:     addr_ok  = 1'b0;
        endcase
    end

    // identity scale over the full line out of reset
    always_ff @(posedge clk) begin
        if (frst) begin
            o_cfg.rate   <= RATE_ONE;
            o_cfg.roi_bw <= '0;
            o_cfg.roi_ew <= LAST_X;
        end else if (access && i_pwrite) begin
            case (i_paddr)
                `REG_RATE:   o_cfg.rate   <= i_pwdata[`COL_W:0];
                `REG_ROI_BW: o_cfg.roi_bw <= i_pwdata[`COL_W:0];
                `REG_ROI_EW: o_cfg.roi_ew <= i_pwdata[`COL_W:0];
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/resize_col_gen.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module resize_col_gen (
    input  logic                    clk,
    input  logic                    frst,
    input  resize_pkg::resize_cfg_t i_cfg,
    input  logic                    i_line_valid,
    input  resize_pkg::line_req_t   i_line,
    output logic                    o_line_ready,
    output logic                    o_busy,
    output resize_pkg::mem_req_t    o_mem_req,
    output resize_pkg::tap_tok_t    o_tok,
    output logic [`FRAC_W-1:0]      o_frac_h,
    input  logic [4:0]              i_fifo_free,
    input  logic                    i_fifo_push
);
    import resize_pkg::*;

    localparam int              PROD_W   = 2 * (`COL_W + 1);
    localparam logic [`COL_W:0] LAST_X   = `LINE_W - 1;
    localparam logic [`COL_W-1:0] LAST_COL = `SRC_W - 1;
    localparam logic [`ROW_W-1:0] LAST_ROW = `SRC_H - 1;

    line_state_e                r_state;
    logic [`COL_W:0]            r_x;
    logic [`COL_W:0]            x_nxt;
    logic [`COL_W:0]            x_off;
    logic                       r_phase;
    logic [4:0]                 r_inflight;
    logic [`ROW_W-1:0]          r_row_up;
    logic [`ROW_W-1:0]          r_row_dn;
    logic [`FRAC_W-1:0]         r_frac_h;
    logic [PROD_W-1:0]          r_prod;
    logic [PROD_W-`FRAC_W-1:0]  int_w;
    logic [`COL_W-1:0]          col0;
    logic [`COL_W-1:0]          col1;
    logic [`FRAC_W-1:0]         frac_w;
    logic                       line_acc;
    logic                       in_roi;
    logic                       issue;
    logic                       pix_start;
    logic                       pix_done;

    assign o_line_ready = (r_state == ST_IDLE);
    assign o_busy       = (r_state != ST_IDLE);
    assign o_frac_h     = r_frac_h;
    assign line_acc     = i_line_valid & o_line_ready;

    assign in_roi = (r_x >= i_cfg.roi_bw) && (r_x <= i_cfg.roi_ew);
    // second read of a pixel always follows, space was reserved at the first
    assign issue     = (r_state == ST_RUN) && (r_phase || (i_fifo_free > r_inflight));
    assign pix_start = issue & ~r_phase;
    assign pix_done  = issue & (r_phase | ~in_roi);

    always_comb begin
        if (line_acc) begin
            x_nxt = '0;
        end else if (pix_done) begin
            x_nxt = r_x + 1'b1;
        end else begin
            x_nxt = r_x;
        end
    end

    // product register follows the column about to be issued
    assign x_off = x_nxt - i_cfg.roi_bw;

    always_ff @(posedge clk) begin
        r_prod <= x_off * i_cfg.rate;
    end

    // clamp at the right edge of the source
    always_comb begin
        int_w = r_prod[PROD_W-1:`FRAC_W];
        if (int_w >= LAST_COL) begin
            col0   = LAST_COL;
            col1   = LAST_COL;
            frac_w = '0;
        end else begin
            col0   = int_w[`COL_W-1:0];
            col1   = col0 + 1'b1;
            frac_w = r_prod[`FRAC_W-1:0];
        end
    end

    always_comb begin
        o_mem_req.re     = issue & in_roi;
        o_mem_req.row_up = r_row_up;
        o_mem_req.row_dn = r_row_dn;
        o_mem_req.col    = r_phase ? col1 : col0;
        o_tok.valid      = issue;
        o_tok.blank      = ~in_roi;
        o_tok.frac_w     = frac_w;
    end

    always_ff @(posedge clk) begin
        if (frst) begin
            r_state    <= ST_IDLE;
            r_x        <= '0;
            r_phase    <= 1'b0;
            r_inflight <= '0;
            r_row_up   <= '0;
            r_row_dn   <= '0;
            r_frac_h   <= '0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (line_acc) begin
                        r_state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (pix_done && (r_x == LAST_X)) begin
                        r_state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (r_inflight == '0) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
            r_x <= x_nxt;
            if (issue && in_roi) begin
                r_phase <= ~r_phase;
            end
            // pixels between first issue and fifo push
            case ({pix_start, i_fifo_push})
                2'b10:   r_inflight <= r_inflight + 1'b1;
                2'b01:   r_inflight <= r_inflight - 1'b1;
                default: ;
            endcase
            // last row pairs with itself
            if (line_acc) begin
                r_row_up <= i_line.h_int;
                if (i_line.h_int == LAST_ROW) begin
                    r_row_dn <= i_line.h_int;
                    r_frac_h <= '0;
                end else begin
                    r_row_dn <= i_line.h_int + 1'b1;
                    r_frac_h <= i_line.h_frac;
                end
            end
        end
    end

endmodule

// File: rtl/resize_tap_gather.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module resize_tap_gather (
    input  logic                 clk,
    input  logic                 frst,
    input  resize_pkg::tap_tok_t i_tok,
    input  resize_pkg::mem_rsp_t i_mem_rsp,
    output resize_pkg::taps_t    o_taps
);
    import resize_pkg::*;

    tap_tok_t           r_tok_q [`MEM_LAT];
    tap_tok_t           tok_d;
    logic               r_second;
    logic [`PIX_W-1:0]  r_up0;
    logic [`PIX_W-1:0]  r_dn0;

    // token lined up with its memory response
    assign tok_d = r_tok_q[`MEM_LAT-1];

    always_ff @(posedge clk) begin
        if (frst) begin
            for (int i = 0; i < `MEM_LAT; i++) begin
                r_tok_q[i] <= '0;
            end
            r_second     <= 1'b0;
            o_taps.valid <= 1'b0;
        end else begin
            r_tok_q[0] <= i_tok;
            for (int i = 1; i < `MEM_LAT; i++) begin
                r_tok_q[i] <= r_tok_q[i-1];
            end
            if (tok_d.valid && !tok_d.blank) begin
                r_second <= ~r_second;
            end
            o_taps.valid <= tok_d.valid && (tok_d.blank || r_second);
            // first response is column 0 of both rows
            if (tok_d.valid && !tok_d.blank && !r_second) begin
                r_up0 <= i_mem_rsp.up;
                r_dn0 <= i_mem_rsp.dn;
            end
            if (tok_d.valid) begin
                o_taps.blank  <= tok_d.blank;
                o_taps.frac_w <= tok_d.frac_w;
                o_taps.up0    <= r_up0;
                o_taps.dn0    <= r_dn0;
                o_taps.up1    <= i_mem_rsp.up;
                o_taps.dn1    <= i_mem_rsp.dn;
            end
        end
    end

endmodule

// File: rtl/bilinear_lerp.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module bilinear_lerp (
    input  logic               clk,
    input  logic               frst,
    input  logic               i_vld,
    input  logic [`FRAC_W-1:0] i_frac_w,
    input  logic [`FRAC_W-1:0] i_frac_h,
    input  logic [7:0]         i_d0,
    input  logic [7:0]         i_d1,
    input  logic [7:0]         i_d2,
    input  logic [7:0]         i_d3,
    output logic               o_vld,
    output logic [7:0]         o_d
);

    // row sums carry one fraction, the final sum two
    localparam int AW = 8 + `FRAC_W;
    localparam int VW = AW + `FRAC_W;

    logic [AW-1:0]          r1_a0, r1_b0;
    logic [7:0]             r1_mag_a, r1_mag_b;
    logic                   r1_pos_a, r1_pos_b;
    logic [`FRAC_W-1:0]     r1_fw, r1_fh;
    logic [AW-1:0]          r2_a0, r2_b0, r2_pa, r2_pb;
    logic                   r2_pos_a, r2_pos_b;
    logic [`FRAC_W-1:0]     r2_fh;
    logic [AW-1:0]          r3_a, r3_b;
    logic [`FRAC_W-1:0]     r3_fh;
    logic [VW-1:0]          r4_a32;
    logic [AW-1:0]          r4_mag;
    logic                   r4_pos;
    logic [`FRAC_W-1:0]     r4_fh;
    logic [VW-1:0]          r5_a32, r5_p;
    logic                   r5_pos;
    logic [VW-1:0]          r6_res;
    logic [`LERP_LAT-1:0]   r_vld;

    always_ff @(posedge clk) begin
        // scaled base and magnitude/sign of the horizontal step
        r1_a0    <= {i_d0, {`FRAC_W{1'b0}}};
        r1_b0    <= {i_d2, {`FRAC_W{1'b0}}};
        r1_pos_a <= (i_d1 >= i_d0);
        r1_pos_b <= (i_d3 >= i_d2);
        r1_mag_a <= (i_d1 >= i_d0) ? i_d1 - i_d0 : i_d0 - i_d1;
        r1_mag_b <= (i_d3 >= i_d2) ? i_d3 - i_d2 : i_d2 - i_d3;
        r1_fw    <= i_frac_w;
        r1_fh    <= i_frac_h;
        r2_a0    <= r1_a0;
        r2_b0    <= r1_b0;
        r2_pa    <= r1_mag_a * r1_fw;
        r2_pb    <= r1_mag_b * r1_fw;
        r2_pos_a <= r1_pos_a;
        r2_pos_b <= r1_pos_b;
        r2_fh    <= r1_fh;
        // horizontal result per row
        r3_a     <= r2_pos_a ? r2_a0 + r2_pa : r2_a0 - r2_pa;
        r3_b     <= r2_pos_b ? r2_b0 + r2_pb : r2_b0 - r2_pb;
        r3_fh    <= r2_fh;
        r4_a32   <= {r3_a, {`FRAC_W{1'b0}}};
        r4_pos   <= (r3_b >= r3_a);
        r4_mag   <= (r3_b >= r3_a) ? r3_b - r3_a : r3_a - r3_b;
        r4_fh    <= r3_fh;
        r5_a32   <= r4_a32;
        r5_p     <= r4_mag * r4_fh;
        r5_pos   <= r4_pos;
        // vertical, never negative
        r6_res   <= r5_pos ? r5_a32 + r5_p : r5_a32 - r5_p;
    end

    always_ff @(posedge clk) begin
        if (frst) begin
            r_vld <= '0;
        end else begin
            r_vld <= {r_vld[`LERP_LAT-2:0], i_vld};
        end
    end

    assign o_vld = r_vld[`LERP_LAT-1];
    assign o_d   = r6_res[VW-1 -: 8];

endmodule

// File: rtl/pixel_out_fifo.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module pixel_out_fifo (
    input  logic              clk,
    input  logic              frst,
    input  logic              i_push,
    input  logic [`PIX_W-1:0] i_data,
    output logic              o_valid,
    output logic [`PIX_W-1:0] o_data,
    input  logic              i_ready,
    output logic [4:0]        o_free
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    logic [`PIX_W-1:0]  r_mem [`FIFO_DEPTH];
    logic [AW-1:0]      r_wr_ptr;
    logic [AW-1:0]      r_rd_ptr;
    logic [4:0]         r_count;
    logic               pop;

    assign o_valid = (r_count != '0);
    assign o_data  = r_mem[r_rd_ptr];
    assign pop     = o_valid & i_ready;
    // the writer reserves space, so a push never meets a full buffer
    assign o_free  = 5'(`FIFO_DEPTH) - r_count;

    always_ff @(posedge clk) begin
        if (i_push) begin
            r_mem[r_wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (frst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/resize_line_top.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module resize_line_top (
    input  logic                  clk,
    input  logic                  frst,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [3:0]            i_paddr,
    input  logic [31:0]           i_pwdata,
    output logic [31:0]           o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    input  logic                  i_line_valid,
    input  resize_pkg::line_req_t i_line,
    output logic                  o_line_ready,
    output resize_pkg::mem_req_t  o_mem_req,
    input  resize_pkg::mem_rsp_t  i_mem_rsp,
    output logic                  o_pix_valid,
    output logic [`PIX_W-1:0]     o_pix,
    input  logic                  i_pix_ready
);
    import resize_pkg::*;

    resize_cfg_t        w_cfg;
    tap_tok_t           w_tok;
    taps_t              w_taps;
    logic               w_busy;
    logic [`FRAC_W-1:0] w_frac_h;
    logic [4:0]         w_fifo_free;
    logic [2:0]         w_lerp_vld;
    logic               w_push;
    logic [`PIX_W-1:0]  w_pix;
    logic [`PIX_W-1:0]  w_up0, w_up1, w_dn0, w_dn1;

    resize_apb_regs u_regs (
        .clk, .frst, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .o_prdata, .o_pready, .o_pslverr, .i_busy(w_busy), .o_cfg(w_cfg)
    );

    resize_col_gen u_col_gen (
        .clk, .frst, .i_cfg(w_cfg), .i_line_valid, .i_line, .o_line_ready,
        .o_busy(w_busy), .o_mem_req, .o_tok(w_tok), .o_frac_h(w_frac_h),
        .i_fifo_free(w_fifo_free), .i_fifo_push(w_push)
    );

    resize_tap_gather u_gather (
        .clk, .frst, .i_tok(w_tok), .i_mem_rsp, .o_taps(w_taps)
    );

    // blank pixels interpolate zeros
    assign w_up0 = w_taps.blank ? '0 : w_taps.up0;
    assign w_up1 = w_taps.blank ? '0 : w_taps.up1;
    assign w_dn0 = w_taps.blank ? '0 : w_taps.dn0;
    assign w_dn1 = w_taps.blank ? '0 : w_taps.dn1;

    // channel 2 is red in the top byte
    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        bilinear_lerp u_lerp (
            .clk, .frst, .i_vld(w_taps.valid), .i_frac_w(w_taps.frac_w), .i_frac_h(w_frac_h),
            .i_d0(w_up0[ch*8 +: 8]), .i_d1(w_up1[ch*8 +: 8]),
            .i_d2(w_dn0[ch*8 +: 8]), .i_d3(w_dn1[ch*8 +: 8]),
            .o_vld(w_lerp_vld[ch]), .o_d(w_pix[ch*8 +: 8])
        );
    end

    assign w_push = &w_lerp_vld;

    pixel_out_fifo u_fifo (
        .clk, .frst, .i_push(w_push), .i_data(w_pix),
        .o_valid(o_pix_valid), .o_data(o_pix), .i_ready(i_pix_ready), .o_free(w_fifo_free)
    );

endmodule

// File: tb/tb_resize_asserts.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module tb_resize_asserts (
    input logic                 clk,
    input logic                 frst,
    input logic                 i_psel,
    input logic                 i_penable,
    input logic                 o_pready,
    input logic                 o_line_ready,
    input resize_pkg::mem_req_t o_mem_req,
    input logic                 o_pix_valid,
    input logic [`PIX_W-1:0]    o_pix,
    input logic                 i_pix_ready
);

    int n_fail = 0;

    // stalled output word must hold
    pix_hold: assert property (@(posedge clk) disable iff (frst)
        o_pix_valid && !i_pix_ready |=> $stable(o_pix))
        else begin
            $error("o_pix changed while the output stream was stalled");
            n_fail++;
        end

    // no memory traffic while waiting for a line
    idle_no_read: assert property (@(posedge clk) disable iff (frst)
        o_mem_req.re |-> !o_line_ready)
        else begin
            $error("memory read issued while the line port was idle");
            n_fail++;
        end

    apb_ready: assert property (@(posedge clk) disable iff (frst)
        o_pready |-> i_psel && i_penable)
        else begin
            $error("pready raised outside an apb access phase");
            n_fail++;
        end

endmodule

// File: tb/tb_resize.sv
`timescale 1ns/1ps
`include "resize_consts.svh"

module tb_resize;
    import resize_pkg::*;

    localparam int          MAX_CYCLES = 6 * `LINE_W * 4 + 200;
    localparam logic [31:0] SEED       = 32'h331decc0;

    logic               clk = 1'b0;
    logic               frst;
    logic               i_psel;
    logic               i_penable;
    logic               i_pwrite;
    logic [3:0]         i_paddr;
    logic [31:0]        i_pwdata;
    logic [31:0]        o_prdata;
    logic               o_pready;
    logic               o_pslverr;
    logic               i_line_valid;
    line_req_t          i_line;
    logic               o_line_ready;
    mem_req_t           o_mem_req;
    mem_rsp_t           i_mem_rsp = '0;
    logic               o_pix_valid;
    logic [`PIX_W-1:0]  o_pix;
    logic               i_pix_ready = 1'b1;

    logic [`PIX_W-1:0]  img [`SRC_H][`SRC_W];
    logic [`PIX_W-1:0]  exp_q [$];
    resize_cfg_t        cfg;
    mem_req_t           mem_req_q = '0;
    logic               bp_on = 1'b0;
    int                 n_err = 0;
    int                 test_err = 0;
    int                 n_tests = 0;
    int                 n_failed = 0;
    int                 cycles = 0;
    logic [31:0]        rd;
    logic               err;

    resize_line_top dut_i (.*);

    bind resize_line_top tb_resize_asserts asserts_i (
        .clk, .frst, .i_psel, .i_penable, .o_pready, .o_line_ready,
        .o_mem_req, .o_pix_valid, .o_pix, .i_pix_ready
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // two-row memory, answers one cycle after the read
    always @(negedge clk) begin
        mem_req_q = o_mem_req;
    end

    always @(posedge clk) begin
        #1;
        if (mem_req_q.re) begin
            i_mem_rsp.up = img[mem_req_q.row_up][mem_req_q.col];
            i_mem_rsp.dn = img[mem_req_q.row_dn][mem_req_q.col];
        end
    end

    // about 30 percent ready under back-pressure
    always @(posedge clk) begin
        #1;
        i_pix_ready = bp_on ? (($urandom % 10) < 3) : 1'b1;
    end

    function automatic logic [`PIX_W-1:0] ref_pixel(input int x, input line_req_t h,
                                                    input resize_cfg_t c);
        int s, i0, i1, fw, r0, r1, fh, a, b, d0, d1, d2, d3;
        logic [`PIX_W-1:0] px;
        px = '0;
        if (x < int'(c.roi_bw) || x > int'(c.roi_ew)) begin
            return px;
        end
        s  = (x - int'(c.roi_bw)) * int'(c.rate);
        i0 = s >> `FRAC_W;
        fw = s % (1 << `FRAC_W);
        if (i0 >= `SRC_W - 1) begin
            i0 = `SRC_W - 1;
            fw = 0;
        end
        i1 = (i0 + 1 > `SRC_W - 1) ? `SRC_W - 1 : i0 + 1;
        r0 = int'(h.h_int);
        if (r0 == `SRC_H - 1) begin
            r1 = r0;
            fh = 0;
        end else begin
            r1 = r0 + 1;
            fh = int'(h.h_frac);
        end
        for (int ch = 0; ch < 3; ch++) begin
            d0 = int'(img[r0][i0][ch*8 +: 8]);
            d1 = int'(img[r0][i1][ch*8 +: 8]);
            d2 = int'(img[r1][i0][ch*8 +: 8]);
            d3 = int'(img[r1][i1][ch*8 +: 8]);
            a  = 32 * d0 + (d1 - d0) * fw;
            b  = 32 * d2 + (d3 - d2) * fw;
            px[ch*8 +: 8] = 8'((32 * a + (b - a) * fh) >>> 10);
        end
        return px;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("error: %s=%h expected=%h", name, got, want);
            n_err++;
        end
    endtask

    // each accepted pixel against the head of the queue
    always @(negedge clk) begin
        if (!frst && o_pix_valid && i_pix_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("output pixel %h arrived when no pixel was expected", o_pix);
                n_err++;
            end
            if (exp_q.size() != 0) begin
                check_value("o_pix", 32'(o_pix), 32'(exp_q.pop_front()));
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic slverr);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = data;
        next_cycle();
        i_penable = 1'b1;
        @(negedge clk);
        assert (o_pready) else begin
            $display("apb access to offset %h ended without pready", addr);
            n_err++;
        end
        rdata  = o_prdata;
        slverr = o_pslverr;
        next_cycle();
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic set_config(input int rate, input int bw, input int ew);
        cfg.rate   = 11'(rate);
        cfg.roi_bw = 11'(bw);
        cfg.roi_ew = 11'(ew);
        apb_xfer(1'b1, `REG_RATE, 32'(rate), rd, err);
        apb_xfer(1'b1, `REG_ROI_BW, 32'(bw), rd, err);
        apb_xfer(1'b1, `REG_ROI_EW, 32'(ew), rd, err);
    endtask

    task automatic request_line(input line_req_t req);
        logic taken;
        taken        = 1'b0;
        i_line       = req;
        i_line_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = o_line_ready;
            next_cycle();
        end
        i_line_valid = 1'b0;
    endtask

    task automatic expect_line(input line_req_t req);
        for (int x = 0; x < `LINE_W; x++) begin
            exp_q.push_back(ref_pixel(x, req, cfg));
        end
    endtask

    task automatic run_line(input line_req_t req);
        expect_line(req);
        request_line(req);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || !o_line_ready) begin
            next_cycle();
        end
    endtask

    task automatic end_test(input string name);
        wait_idle();
        // room for stray pixels to show up
        repeat (2 * `LERP_LAT) next_cycle();
        n_tests++;
        if (n_err == test_err) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, n_err - test_err);
            n_failed++;
        end
        test_err = n_err;
    endtask

    initial begin
        frst         = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_line_valid = 1'b0;
        i_line       = '0;
        cfg          = '0;
        void'($urandom(SEED));
        for (int r = 0; r < `SRC_H; r++) begin
            for (int c = 0; c < `SRC_W; c++) begin
                img[r][c] = `PIX_W'($urandom);
            end
        end
        repeat (3) @(posedge clk);
        #1;
        frst = 1'b0;

        set_config(24, 3, 50);
        apb_xfer(1'b0, `REG_RATE, '0, rd, err);
        check_value("prdata", rd, 32'd24);
        apb_xfer(1'b0, `REG_ROI_BW, '0, rd, err);
        check_value("prdata", rd, 32'd3);
        apb_xfer(1'b0, `REG_ROI_EW, '0, rd, err);
        check_value("prdata", rd, 32'd50);
        check_value("pslverr", 32'(err), 32'd0);
        apb_xfer(1'b0, `REG_STATUS, '0, rd, err);
        check_value("prdata", rd, 32'd0);
        // unmapped offset inside the 4-bit address space
        apb_xfer(1'b1, 4'h6, 32'h55, rd, err);
        check_value("pslverr", 32'(err), 32'd1);
        end_test("registers");

        // unit rate copies the row, clamped at the right edge
        set_config(32, 0, `LINE_W - 1);
        for (int x = 0; x < `LINE_W; x++) begin
            exp_q.push_back(img[7][(x < `SRC_W) ? x : `SRC_W - 1]);
        end
        request_line({10'd7, 5'd0});
        end_test("identity line");

        set_config(16, 0, `LINE_W - 1);
        run_line({10'd5, 5'd16});
        end_test("scaled line");

        set_config(24, 10, 40);
        run_line({10'd31, 5'd12});
        end_test("partial region");

        set_config(16, 0, `LINE_W - 1);
        bp_on = 1'b1;
        run_line({10'd5, 5'd16});
        apb_xfer(1'b0, `REG_STATUS, '0, rd, err);
        check_value("prdata", rd, 32'd1);
        wait_idle();
        bp_on = 1'b0;
        end_test("back-pressure");

        set_config(20, 0, `LINE_W - 1);
        run_line({10'd3, 5'd25});
        run_line({10'd17, 5'd0});
        run_line({10'd30, 5'd8});
        end_test("back-to-back lines");

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 n_tests, n_failed, n_err, dut_i.asserts_i.n_fail);
        if (n_err == 0 && dut_i.asserts_i.n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/resize_pkg.sv
rtl/resize_apb_regs.sv
rtl/resize_col_gen.sv
rtl/resize_tap_gather.sv
rtl/bilinear_lerp.sv
rtl/pixel_out_fifo.sv
rtl/resize_line_top.sv
tb/tb_resize_asserts.sv
tb/tb_resize.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_resize
SEED      ?= 1
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' tb.f)
HDRS := include/resize_consts.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): tb.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f

run: $(SIM)
	./$(SIM) +verilator+seed+$(SEED) +verilator+error+limit+100 | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
